//--- read_cache_top.f
hw/cache_pkg.sv
hw/line_fill_if.sv
hw/line_fill_axi.sv
hw/cache_tag_store.sv
hw/cache_data_store.sv
hw/cache_ctrl.sv
hw/read_cache_top.sv
verif/axi_read_mem_model.sv
verif/tb_read_cache.sv

//--- run_sim.sh
#!/bin/bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps -j 0 \
   --top-module tb_read_cache -f read_cache_top.f -o sim_read_cache

out=$(./obj_dir/sim_read_cache)
echo "$out"

if echo "$out" | grep -qx "ALL CHECKS PASSED"; then
   exit 0
else
   exit 1
fi

//--- verif/tb_read_cache.sv
`timescale 1ns/1ps

module tb_read_cache;

   localparam int aw         = cache_pkg::addr_w;
   localparam int dw         = cache_pkg::data_w;
   localparam int wait_limit = 400;  // cycles per handshake phase

   logic          clk = 1'b0;
   logic          reset = 1'b1;
   logic          req = 1'b0;
   logic [aw-1:0] addr = '0;
   logic          ack;
   logic [dw-1:0] rdata;
   logic [aw-1:0] axi_araddr;
   logic          axi_arvalid;
   logic          axi_arready;
   logic [dw-1:0] axi_rdata;
   logic [1:0]    axi_rresp;
   logic          axi_rlast;
   logic          axi_rvalid;
   logic          axi_rready;
   int            err_burst = 0;
   logic [1:0]    err_beat = 2'd2;
   logic [31:0]   lcg_state = 32'd82;
   logic [7:0]    shadow_valid = '0;
   logic [8:0]    shadow_tag [8];
   logic [aw-1:0] ar_seen [$];  // araddr of every accepted AR
   int            expect_ar = 0;
   int            checks = 0;
   int            errors = 0;
   logic          hung = 1'b0;
   logic          ack_q = 1'b0;

   read_cache_top read_cache_top_i (.*);

   axi_read_mem_model mem_model_i (.*);

   always #2 clk = ~clk;

   function automatic logic [31:0] next_rand();
      lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
      return lcg_state;
   endfunction

   // expected memory word for a byte address
   function automatic logic [dw-1:0] mem_word(logic [aw-1:0] a);
      logic [15:0] wa;
      wa = {2'b00, a[15:2]};
      return {wa ^ 16'h5a3c, wa * 16'd40503};
   endfunction

   // index is a[6:4], tag a[15:7]; returns 1 on a predicted miss
   function automatic int predict_fills(logic [aw-1:0] a);
      if (shadow_valid[a[6:4]] && shadow_tag[a[6:4]] == a[15:7])
         return 0;
      shadow_valid[a[6:4]] = 1'b1;
      shadow_tag[a[6:4]]   = a[15:7];
      return 1;
   endfunction

   task automatic check_value(string name, logic [31:0] got, logic [31:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("error at %0t: %s is %h, expected %h", $time, name, got, exp);
      end
   endtask

   // one four-phase transaction, latency counted from the edge that samples req
   task automatic read_word(logic [aw-1:0] a, output int latency);
      int n;
      latency = 0;
      if (!hung) begin
         addr = a;
         req  = 1'b1;
         n    = 0;
         while (ack !== 1'b1 && n < wait_limit) begin
            @(posedge clk);
            #0.5;
            n++;
         end
         latency = n - 1;
         req     = 1'b0;
         if (ack !== 1'b1) begin
            $display("timeout: no ack for the read of %h", a);
            hung = 1'b1;
         end
         n = 0;
         while (ack !== 1'b0 && n < wait_limit) begin
            @(posedge clk);
            #0.5;
            n++;
         end
         if (ack !== 1'b0) begin
            $display("timeout: ack stayed high after req dropped");
            hung = 1'b1;
         end else if (!hung) begin
            check_value("ack_fall", n, 1);  // one edge after req is seen low
         end
      end
   endtask

   task automatic end_test(string name, int errors_before);
      $display("test %s: %0d errors", name, errors - errors_before);
   endtask

   // rdata compared on every rising ack
   always @(negedge clk) begin
      if (ack && !ack_q)
         check_value("rdata", rdata, mem_word(addr));
      ack_q = ack;
   end

   always @(negedge clk) begin
      if (axi_arvalid && axi_arready)
         ar_seen.push_back(axi_araddr);
   end

   initial begin
      int            lat;
      int            e0;
      int            n0;
      logic [31:0]   r;
      logic [aw-1:0] a;
      repeat (3) @(posedge clk);
      #0.5;

      e0 = errors;
      check_value("ack", {31'b0, ack}, 32'h0);
      check_value("axi_arvalid", {31'b0, axi_arvalid}, 32'h0);
      check_value("axi_rready", {31'b0, axi_rready}, 32'h0);
      end_test("reset", e0);
      reset = 1'b0;

      e0 = errors;
      expect_ar += predict_fills(16'h1234);
      read_word(16'h1234, lat);
      check_value("ar_count", ar_seen.size(), expect_ar);
      if (ar_seen.size() > 0)
         check_value("araddr", {16'h0, ar_seen[0]}, 32'h1230);
      end_test("cold miss", e0);

      e0 = errors;
      for (int w = 0; w < 4; w++) begin
         a = 16'h1230 | 16'(w * 5);  // other words, odd byte offsets too
         if (a[3:2] != 2'b01) begin
            expect_ar += predict_fills(a);
            read_word(a, lat);
            check_value("hit_latency", lat, 2);
         end
      end
      check_value("ar_count", ar_seen.size(), expect_ar);
      end_test("hit", e0);

      e0 = errors;
      expect_ar += predict_fills(16'h1ab4);  // same index, other tag
      read_word(16'h1ab4, lat);
      expect_ar += predict_fills(16'h1234);
      read_word(16'h1234, lat);
      check_value("ar_count", ar_seen.size(), expect_ar);
      end_test("conflict", e0);

      e0 = errors;
      n0 = ar_seen.size();
      err_burst = n0 + 1;
      expect_ar += predict_fills(16'h5678) + 1;  // one retry
      read_word(16'h5678, lat);
      err_burst = 0;
      check_value("ar_count", ar_seen.size(), expect_ar);
      if (ar_seen.size() >= n0 + 2) begin
         check_value("araddr", {16'h0, ar_seen[n0]}, 32'h5670);
         check_value("araddr_retry", {16'h0, ar_seen[n0+1]}, 32'h5670);
      end
      end_test("slave error", e0);

      e0 = errors;
      for (int i = 0; i < 200 && !hung; i++) begin
         r = next_rand();
         a = (r[23:8] & 16'h01ff) | 16'ha000;  // four tags, so some reads hit
         expect_ar += predict_fills(a);
         read_word(a, lat);
      end
      check_value("ar_count", ar_seen.size(), expect_ar);
      end_test("random traffic", e0);

      $display("%0d checks, %0d errors%s", checks, errors, hung ? ", stopped on a timeout" : "");
      if (errors == 0 && !hung)
         $display("ALL CHECKS PASSED");
      else
         $display("CHECKS FAILED");
      $finish;
   end

endmodule

//--- verif/axi_read_mem_model.sv
`timescale 1ns/1ps

module axi_read_mem_model (
   input  logic                         clk,
   input  logic                         reset,
   input  logic [cache_pkg::addr_w-1:0] axi_araddr,
   input  logic                         axi_arvalid,
   output logic                         axi_arready,
   output logic [cache_pkg::data_w-1:0] axi_rdata,
   output logic [1:0]                   axi_rresp,
   output logic                         axi_rlast,
   output logic                         axi_rvalid,
   input  logic                         axi_rready,
   input  int                           err_burst,  // burst number that gets SLVERR, 0 for none
   input  logic [1:0]                   err_beat
);

   logic [31:0] lcg_state = 32'd82;
   logic [31:0] rnd;
   logic [15:0] base;
   logic [1:0]  beat;
   logic        busy;
   logic        ar_hs;
   logic        r_hs;
   int          bursts;  // accepted AR requests since reset

   function automatic logic [31:0] next_rand();
      lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
      return lcg_state;
   endfunction

   // memory contents, one word per word address
   function automatic logic [31:0] mem_word(logic [15:0] a);
      logic [15:0] wa;
      wa = {2'b00, a[15:2]};
      return {wa ^ 16'h5a3c, wa * 16'd40503};
   endfunction

   initial begin
      axi_arready = 1'b0;
      axi_rvalid  = 1'b0;
      axi_rlast   = 1'b0;
      axi_rresp   = 2'b00;
      axi_rdata   = '0;
      busy        = 1'b0;
      beat        = 2'd0;
      bursts      = 0;
      forever begin
         @(negedge clk);
         ar_hs = axi_arvalid && axi_arready;  // what the next edge will take
         r_hs  = axi_rvalid && axi_rready;
         @(posedge clk);
         #0.5;
         if (reset) begin
            axi_arready = 1'b0;
            axi_rvalid  = 1'b0;
            busy        = 1'b0;
            bursts      = 0;
         end else begin
            if (ar_hs) begin
               busy   = 1'b1;
               base   = axi_araddr;
               beat   = 2'd0;
               bursts = bursts + 1;
            end
            if (r_hs) begin
               if (axi_rlast)
                  busy = 1'b0;
               else
                  beat = beat + 2'd1;
            end
            // a beat on offer stays until it is taken
            if (!axi_rvalid || r_hs) begin
               rnd        = next_rand();
               axi_rvalid = busy && (rnd[9:8] != 2'b00);
               axi_rlast  = (beat == 2'd3);
               axi_rresp  = (bursts == err_burst && beat == err_beat) ? 2'b10 : 2'b00;
               axi_rdata  = mem_word({base[15:4], beat, 2'b00});
               if (axi_rresp != 2'b00)
                  axi_rdata = ~axi_rdata;  // error beat carries no usable data
            end
            rnd         = next_rand();
            axi_arready = !busy && (rnd[9:8] != 2'b00);
         end
      end
   end

endmodule

//--- hw/read_cache_top.sv
`timescale 1ns/1ps

module read_cache_top (
   input  logic                         clk,
   input  logic                         reset,
   // requester
   input  logic                         req,
   input  logic [cache_pkg::addr_w-1:0] addr,
   output logic                         ack,
   output logic [cache_pkg::data_w-1:0] rdata,
   // AXI read channel
   output logic [cache_pkg::addr_w-1:0] axi_araddr,
   output logic                         axi_arvalid,
   input  logic                         axi_arready,
   input  logic [cache_pkg::data_w-1:0] axi_rdata,
   input  logic [1:0]                   axi_rresp,
   input  logic                         axi_rlast,
   input  logic                         axi_rvalid,
   output logic                         axi_rready
);

   logic                             hit;
   logic                             fill_en;
   logic [cache_pkg::index_w-1:0]    lookup_index;
   logic [cache_pkg::tag_w-1:0]      lookup_tag;
   logic [cache_pkg::index_w-1:0]    fill_index;
   logic [cache_pkg::tag_w-1:0]      fill_tag;
   logic [cache_pkg::index_w-1:0]    rd_index;
   logic [cache_pkg::word_off_w-1:0] rd_word;
   logic [cache_pkg::data_w-1:0]     rd_data;

   line_fill_if fill_bus ();

   cache_ctrl cache_ctrl_i (
      .clk          (clk),
      .reset        (reset),
      .req          (req),
      .addr         (addr),
      .ack          (ack),
      .rdata        (rdata),
      .lookup_index (lookup_index),
      .lookup_tag   (lookup_tag),
      .hit          (hit),
      .fill_en      (fill_en),
      .fill_index   (fill_index),
      .fill_tag     (fill_tag),
      .rd_index     (rd_index),
      .rd_word      (rd_word),
      .rd_data      (rd_data),
      .fill         (fill_bus.ctrl)
   );

   cache_tag_store cache_tag_store_i (
      .clk          (clk),
      .reset        (reset),
      .lookup_index (lookup_index),
      .lookup_tag   (lookup_tag),
      .hit          (hit),
      .fill_en      (fill_en),
      .fill_index   (fill_index),
      .fill_tag     (fill_tag)
   );

   cache_data_store cache_data_store_i (
      .clk      (clk),
      .rd_index (rd_index),
      .rd_word  (rd_word),
      .rd_data  (rd_data),
      .fill     (fill_bus.store)
   );

   line_fill_axi line_fill_axi_i (
      .clk     (clk),
      .reset   (reset),
      .fill    (fill_bus.fill),
      .araddr  (axi_araddr),
      .arvalid (axi_arvalid),
      .arready (axi_arready),
      .rdata   (axi_rdata),
      .rresp   (axi_rresp),
      .rlast   (axi_rlast),
      .rvalid  (axi_rvalid),
      .rready  (axi_rready)
   );

endmodule

//--- hw/cache_ctrl.sv
`timescale 1ns/1ps

module cache_ctrl (
   input  logic                             clk,
   input  logic                             reset,
   input  logic                             req,
   input  cache_pkg::cache_addr_u           addr,
   output logic                             ack,
   output logic [cache_pkg::data_w-1:0]     rdata,
   output logic [cache_pkg::index_w-1:0]    lookup_index,
   output logic [cache_pkg::tag_w-1:0]      lookup_tag,
   input  logic                             hit,
   output logic                             fill_en,
   output logic [cache_pkg::index_w-1:0]    fill_index,
   output logic [cache_pkg::tag_w-1:0]      fill_tag,
   output logic [cache_pkg::index_w-1:0]    rd_index,
   output logic [cache_pkg::word_off_w-1:0] rd_word,
   input  logic [cache_pkg::data_w-1:0]     rd_data,
   line_fill_if.ctrl                        fill
);

   localparam int line_addr_w = cache_pkg::tag_w + cache_pkg::index_w;

   typedef enum logic [2:0] {
      wait_req,
      lookup,        // tag compare, data read issued
      respond,       // word ready from the store
      start_fill,
      wait_fill,
      wait_release   // ack high until req drops
   } ctrl_state_e;

   ctrl_state_e           state;
   cache_pkg::cache_addr_u addr_q;

   assign lookup_index = addr_q.f.index;
   assign lookup_tag   = addr_q.f.tag;
   assign rd_index     = addr_q.f.index;
   assign rd_word      = addr_q.f.word_off;
   assign fill_index   = addr_q.f.index;
   assign fill_tag     = addr_q.f.tag;

   assign fill.replace_addr = addr_q.flat[cache_pkg::addr_w-1 -: line_addr_w];

   // low on the cycle replace falls, so the tag store marks the line valid
   // on the same edge the FSM returns to lookup
   assign fill_en = (state == start_fill) || (state == wait_fill && fill.replace);

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         state              <= wait_req;
         ack                <= 1'b0;
         fill.replace_valid <= 1'b0;
      end else begin
         case (state)
            wait_req: begin
               if (req)
                  state <= lookup;
            end
            lookup: begin
               if (hit) begin
                  state <= respond;
               end else begin
                  state              <= start_fill;
                  fill.replace_valid <= 1'b1;
               end
            end
            respond: begin
               ack   <= 1'b1;
               state <= wait_release;
            end
            start_fill: begin
               if (fill.replace) begin  // fill block took it
                  fill.replace_valid <= 1'b0;
                  state              <= wait_fill;
               end
            end
            wait_fill: begin
               if (!fill.replace)
                  state <= lookup;  // line now valid, this lookup hits
            end
            default: begin
               if (!req) begin
                  ack   <= 1'b0;  // drops on the edge that sees req low
                  state <= wait_req;
               end
            end
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (state == wait_req && req)
         addr_q <= addr;  // held for the whole transaction
      if (state == respond)
         rdata <= rd_data;
   end

endmodule

//--- hw/cache_data_store.sv
`timescale 1ns/1ps

module cache_data_store (
   input  logic                             clk,
   input  logic [cache_pkg::index_w-1:0]    rd_index,
   input  logic [cache_pkg::word_off_w-1:0] rd_word,
   output logic [cache_pkg::data_w-1:0]     rd_data,
   line_fill_if.store                       fill
);

   localparam int depth = (1 << cache_pkg::index_w) * cache_pkg::line_words;

   logic [cache_pkg::data_w-1:0]   mem [depth];
   logic [cache_pkg::index_w-1:0]  wr_index;

   // index is the low part of the line address
   assign wr_index = fill.replace_addr[cache_pkg::index_w-1:0];

   always_ff @(posedge clk) begin
      if (fill.read_valid)
         mem[{wr_index, fill.read_addr}] <= fill.read_rdata;
      rd_data <= mem[{rd_index, rd_word}];  // one cycle read
   end

endmodule

//--- hw/cache_tag_store.sv
`timescale 1ns/1ps

module cache_tag_store (
   input  logic                          clk,
   input  logic                          reset,
   input  logic [cache_pkg::index_w-1:0] lookup_index,
   input  logic [cache_pkg::tag_w-1:0]   lookup_tag,
   output logic                          hit,
   input  logic                          fill_en,
   input  logic [cache_pkg::index_w-1:0] fill_index,
   input  logic [cache_pkg::tag_w-1:0]   fill_tag
);

   localparam int lines = 1 << cache_pkg::index_w;

   logic [lines-1:0]              valid;
   logic [cache_pkg::tag_w-1:0]   tags [lines];
   logic                          fill_en_q;

   assign hit = valid[lookup_index] && (tags[lookup_index] == lookup_tag);

   // line goes invalid while fill_en is high, valid again on its falling edge
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         valid     <= '0;
         fill_en_q <= 1'b0;
      end else begin
         fill_en_q <= fill_en;
         if (fill_en)
            valid[fill_index] <= 1'b0;
         else if (fill_en_q)
            valid[fill_index] <= 1'b1;  // fill done
      end
   end

   always_ff @(posedge clk) begin
      if (fill_en)
         tags[fill_index] <= fill_tag;
   end

endmodule

//--- hw/line_fill_axi.sv
`timescale 1ns/1ps

module line_fill_axi (
   input  logic                            clk,
   input  logic                            reset,
   line_fill_if.fill                       fill,
   output logic [cache_pkg::addr_w-1:0]    araddr,
   output logic                            arvalid,
   input  logic                            arready,
   input  logic [cache_pkg::data_w-1:0]    rdata,
   input  logic [1:0]                      rresp,
   input  logic                            rlast,
   input  logic                            rvalid,
   output logic                            rready
);

   cache_pkg::fill_state_e state;
   logic                   slave_error;  // sticky over the whole burst

   // burst starts at word 0 of the line
   assign araddr = {fill.replace_addr, {(cache_pkg::word_off_w + cache_pkg::byte_w){1'b0}}};

   assign fill.read_rdata = rdata;
   assign fill.read_valid = rvalid && rready;

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         state          <= cache_pkg::idle;
         fill.read_addr <= '0;
         slave_error    <= 1'b0;
      end else begin
         case (state)
            cache_pkg::idle: begin
               fill.read_addr <= '0;
               slave_error    <= 1'b0;
               if (fill.replace_valid)
                  state <= cache_pkg::addr_phase;
            end
            cache_pkg::addr_phase: begin
               fill.read_addr <= '0;
               slave_error    <= 1'b0;  // fresh attempt
               if (arready)
                  state <= cache_pkg::data_phase;
            end
            cache_pkg::data_phase: begin
               if (rvalid) begin
                  if (rresp != 2'b00)
                     slave_error <= 1'b1;  // burst cannot be cut, finish it first
                  if (rlast)
                     state <= cache_pkg::end_phase;  // hold read_addr on the last beat
                  else
                     fill.read_addr <= fill.read_addr + 1'b1;
               end
            end
            default: begin
               // last beat is in the store by now
               if (slave_error)
                  state <= cache_pkg::addr_phase;
               else
                  state <= cache_pkg::idle;
            end
         endcase
      end
   end

   always_comb begin
      arvalid      = 1'b0;
      rready       = 1'b0;
      fill.replace = 1'b1;
      case (state)
         cache_pkg::idle:       fill.replace = 1'b0;
         cache_pkg::addr_phase: arvalid      = 1'b1;
         cache_pkg::data_phase: rready       = 1'b1;
         default:               ;
      endcase
   end

endmodule

//--- hw/line_fill_if.sv
`timescale 1ns/1ps

interface line_fill_if;

   logic                                          replace_valid;  // ctrl asks for a fill
   logic [cache_pkg::tag_w+cache_pkg::index_w-1:0] replace_addr;  // line address
   logic                                          replace;        // fill busy
   logic                                          read_valid;     // one beat this cycle
   logic [cache_pkg::word_off_w-1:0]              read_addr;      // word within line
   logic [cache_pkg::data_w-1:0]                  read_rdata;

   modport ctrl (
      output replace_valid, replace_addr,
      input  replace
   );

   modport fill (
      input  replace_valid, replace_addr,
      output replace, read_valid, read_addr, read_rdata
   );

   modport store (
      input read_valid, read_addr, read_rdata, replace_addr
   );

endinterface

//--- hw/cache_pkg.sv
package cache_pkg;

   localparam int addr_w     = 16;  // byte address
   localparam int data_w     = 32;  // word and AXI data width
   localparam int byte_w     = 2;   // byte within word
   localparam int word_off_w = 2;   // word within line
   localparam int index_w    = 3;   // 8 lines
   localparam int tag_w      = addr_w - index_w - word_off_w - byte_w;
   localparam int line_words = 1 << word_off_w;  // beats per burst

   typedef struct packed {
      logic [tag_w-1:0]      tag;
      logic [index_w-1:0]    index;
      logic [word_off_w-1:0] word_off;
      logic [byte_w-1:0]     byte_off;
   } cache_addr_s;

   // same request word, seen flat or split into cache fields
   typedef union packed {
      logic [addr_w-1:0] flat;
      cache_addr_s       f;
   } cache_addr_u;

   typedef enum logic [1:0] {
      idle,
      addr_phase,   // arvalid out, waiting for arready
      data_phase,   // taking beats
      end_phase     // one cycle, then retry or release
   } fill_state_e;

endpackage
